// File: logic/agg_pkg.sv
/*
  aggregation kernel shared types: widths, instruction and edge layouts,
  buffer request ports, pipeline tag and controller states
*/
package agg_pkg;

  ////////////////////
  // sizes and latency
  ////////////////////
  localparam int LANES          = 4;
  localparam int LANE_W         = 16;
  localparam int FEAT_W         = 64;
  localparam int EDGES_PER_BEAT = 4;
  localparam int BUF_AW         = 11;
  localparam int BIAS_AW        = 9;
  // request to read data, in cycles
  localparam int BUF_RD_LAT     = 4;

  typedef logic signed [LANE_W-1:0] lane_t;
  typedef logic [FEAT_W-1:0]        feat_word_t;
  typedef logic [BUF_AW-1:0]        buf_addr_t;
  typedef logic [BIAS_AW-1:0]       bias_addr_t;

  ////////////////////
  // stream and instruction
  ////////////////////
  // one packed edge, msb first
  typedef struct packed {
    logic        first;
    logic [14:0] dst;
    logic        last;
    logic [14:0] src;
    // only the low lane_t part is used
    logic [31:0] weight;
  } edge_t;

  typedef logic [EDGES_PER_BEAT*$bits(edge_t)-1:0] edge_beat_t;

  typedef struct packed {
    logic [60:0] pad;
    // multiple of four
    logic [15:0] edge_count;
    logic [15:0] out_start;
    logic [7:0]  addr_per_feature;
    logic [7:0]  bias_start;
    logic [15:0] in_start;
    logic        bias_en;
    logic        relu_en;
    // input bank is b, output bank is a
    logic        in_is_b;
  } agg_instr_t;

  ////////////////////
  // buffer ports and pipeline tag
  ////////////////////
  typedef struct packed {
    logic      valid;
    buf_addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic       valid;
    buf_addr_t  addr;
    feat_word_t data;
  } wr_req_t;

  typedef struct packed {
    logic      valid;
    logic      first;
    logic      last;
    // last feature word of the edge
    logic      finish;
    buf_addr_t out_addr;
    lane_t     weight;
  } stage_tag_t;

  typedef enum logic [2:0] {
    IDLE,
    DECODE,
    WAIT_BEAT,
    ISSUE,
    DRAIN
  } ctrl_state_t;

endpackage

// File: logic/agg_ctrl.sv
/*
  aggregation controller: latches and decodes the instruction, takes edge
  beats, walks the edges one by one and sequences the feature addresses
*/
`timescale 1ns/1ps

module agg_ctrl
  import agg_pkg::*;
(
  input  logic       kernel_rst,
  input  logic       kernel_clk,
  input  logic       start,
  input  agg_instr_t instr,
  output logic       done,
  input  logic       edge_valid,
  input  edge_beat_t edge_data,
  output logic       edge_ready,
  output agg_instr_t cfg,
  output stage_tag_t issue,
  output buf_addr_t  in_addr,
  output bias_addr_t bias_addr,
  input  logic       wb_finish
);

  ctrl_state_t state;
  edge_beat_t  beat_q;
  edge_t       cur_edge;
  logic [1:0]  edge_idx;
  logic [7:0]  feat_cnt;
  logic [15:0] beats_left;
  logic        last_feat;
  logic        beat_taken;
  logic [23:0] in_full;
  logic [23:0] out_full;

  // edge under work sits in the low bits of the beat register
  assign cur_edge   = edge_t'(beat_q[$bits(edge_t)-1:0]);
  assign last_feat  = (feat_cnt == cfg.addr_per_feature - 8'd1);
  assign edge_ready = (state == WAIT_BEAT);
  assign beat_taken = edge_ready && edge_valid;

  ////////////////////
  // state machine
  ////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      state      <= IDLE;
      cfg        <= '0;
      edge_idx   <= '0;
      feat_cnt   <= '0;
      beats_left <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            cfg   <= instr;
            state <= DECODE;
          end
        end
        DECODE: begin
          beats_left <= cfg.edge_count / 16'(EDGES_PER_BEAT);
          // empty instruction finishes straight away
          if (cfg.edge_count == '0) begin
            done  <= 1'b1;
            state <= IDLE;
          end else begin
            state <= WAIT_BEAT;
          end
        end
        WAIT_BEAT: begin
          if (beat_taken) begin
            edge_idx <= '0;
            feat_cnt <= '0;
            state    <= ISSUE;
          end
        end
        ISSUE: begin
          // one feature word per cycle
          if (last_feat) begin
            state <= DRAIN;
          end else begin
            feat_cnt <= feat_cnt + 8'd1;
          end
        end
        DRAIN: begin
          // hold the next edge until the finish write lands
          if (wb_finish) begin
            feat_cnt <= '0;
            if (edge_idx == 2'(EDGES_PER_BEAT - 1)) begin
              if (beats_left <= 16'd1) begin
                done  <= 1'b1;
                state <= IDLE;
              end else begin
                beats_left <= beats_left - 16'd1;
                state      <= WAIT_BEAT;
              end
            end else begin
              edge_idx <= edge_idx + 2'd1;
              state    <= ISSUE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // beat register, shifted one edge down per finished edge
  always_ff @(posedge kernel_rst) begin
    if (beat_taken) begin
      beat_q <= edge_data;
    end else if (state == DRAIN && wb_finish) begin
      beat_q <= beat_q >> $bits(edge_t);
    end
  end

  ////////////////////
  // addresses and issue tag
  ////////////////////
  assign in_full  = 24'(cfg.in_start) + 24'(cur_edge.src) * 24'(cfg.addr_per_feature)
                  + 24'(feat_cnt);
  assign out_full = 24'(cfg.out_start) + 24'(cur_edge.dst) * 24'(cfg.addr_per_feature)
                  + 24'(feat_cnt);

  assign in_addr   = in_full[BUF_AW-1:0];
  assign bias_addr = BIAS_AW'(cfg.bias_start) + BIAS_AW'(feat_cnt);

  always_comb begin
    issue.valid    = (state == ISSUE);
    issue.first    = cur_edge.first;
    issue.last     = cur_edge.last;
    issue.finish   = last_feat;
    issue.out_addr = out_full[BUF_AW-1:0];
    issue.weight   = lane_t'(cur_edge.weight[LANE_W-1:0]);
  end

endmodule

// File: logic/agg_fetch.sv
/*
  aggregation fetch stage: drives bank and bias reads and delays the
  request tag to line up with the returning buffer data
*/
`timescale 1ns/1ps

module agg_fetch
  import agg_pkg::*;
(
  input  logic       kernel_rst,
  input  logic       kernel_clk,
  input  agg_instr_t cfg,
  input  stage_tag_t issue,
  input  buf_addr_t  in_addr,
  input  bias_addr_t bias_addr,
  output rd_req_t    rd_a,
  output rd_req_t    rd_b,
  input  feat_word_t rd_a_data,
  input  feat_word_t rd_b_data,
  output logic       bias_rd_valid,
  output bias_addr_t bias_rd_addr,
  input  feat_word_t bias_data,
  output stage_tag_t tag,
  output feat_word_t in_word,
  output feat_word_t out_word,
  output feat_word_t bias_word
);

  stage_tag_t tag_pipe [BUF_RD_LAT];

  ////////////////////
  // read requests
  ////////////////////
  // input address goes to the input bank, output address to the other
  always_comb begin
    rd_a.valid = issue.valid;
    rd_a.addr  = cfg.in_is_b ? issue.out_addr : in_addr;
    rd_b.valid = issue.valid;
    rd_b.addr  = cfg.in_is_b ? in_addr : issue.out_addr;
  end

  assign bias_rd_valid = issue.valid;
  assign bias_rd_addr  = bias_addr;

  ////////////////////
  // tag delay line
  ////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      for (int i = 0; i < BUF_RD_LAT; i++) begin
        tag_pipe[i] <= '0;
      end
    end else begin
      tag_pipe[0] <= issue;
      for (int i = 1; i < BUF_RD_LAT; i++) begin
        tag_pipe[i] <= tag_pipe[i-1];
      end
    end
  end

  assign tag = tag_pipe[BUF_RD_LAT-1];

  // returned words steered back by the same bank bit
  assign in_word   = cfg.in_is_b ? rd_b_data : rd_a_data;
  assign out_word  = cfg.in_is_b ? rd_a_data : rd_b_data;
  assign bias_word = bias_data;

endmodule

// File: logic/agg_mac.sv
/*
  aggregation multiply-accumulate: lane-wise weight multiply, then add of
  the stored output word unless the edge is marked first
*/
`timescale 1ns/1ps

module agg_mac
  import agg_pkg::*;
(
  input  logic       kernel_rst,
  input  logic       kernel_clk,
  input  stage_tag_t tag,
  input  feat_word_t in_word,
  input  feat_word_t out_word,
  input  feat_word_t bias_word,
  input  lane_t      weight,
  output stage_tag_t add_tag,
  output feat_word_t sum,
  output feat_word_t add_bias
);

  stage_tag_t mul_tag;
  feat_word_t mul_word;
  feat_word_t mul_out;
  feat_word_t mul_bias;
  feat_word_t prod_word;
  feat_word_t acc_word;

  // keep the low half of the product, wraps like the lanes
  function automatic lane_t lane_mul(lane_t a, lane_t b);
    logic signed [2*LANE_W-1:0] p;
    p = a * b;
    return p[LANE_W-1:0];
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      prod_word[i*LANE_W +: LANE_W] = lane_mul(in_word[i*LANE_W +: LANE_W], weight);
      // first edge of a destination starts from zero
      acc_word[i*LANE_W +: LANE_W] = mul_word[i*LANE_W +: LANE_W]
                                   + (mul_tag.first ? '0 : mul_out[i*LANE_W +: LANE_W]);
    end
  end

  ////////////////////
  // stage registers
  ////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      mul_tag <= '0;
      add_tag <= '0;
    end else begin
      mul_tag <= tag;
      add_tag <= mul_tag;
    end
  end

  always_ff @(posedge kernel_rst) begin
    mul_word <= prod_word;
    mul_out  <= out_word;
    mul_bias <= bias_word;
    sum      <= acc_word;
    add_bias <= mul_bias;
  end

endmodule

// File: logic/agg_bias_relu.sv
/*
  aggregation write-back stage: bias and ReLU on the last edge, then the
  write request to the output bank
*/
`timescale 1ns/1ps

module agg_bias_relu
  import agg_pkg::*;
(
  input  logic       kernel_rst,
  input  logic       kernel_clk,
  input  agg_instr_t cfg,
  input  stage_tag_t tag,
  input  feat_word_t sum,
  input  feat_word_t bias_word,
  output wr_req_t    wr_a,
  output wr_req_t    wr_b,
  output logic       wb_finish
);

  stage_tag_t wb_tag;
  feat_word_t wb_word;
  feat_word_t res_word;
  logic       bias_on;
  logic       relu_on;

  function automatic lane_t bias_relu_lane(lane_t acc, lane_t bias, logic add_b, logic clamp);
    lane_t v;
    v = add_b ? lane_t'(acc + bias) : acc;
    return (clamp && v[LANE_W-1]) ? '0 : v;
  endfunction

  // only the edge marked last gets bias and relu
  assign bias_on = tag.last && cfg.bias_en;
  assign relu_on = tag.last && cfg.relu_en;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      res_word[i*LANE_W +: LANE_W] = bias_relu_lane(sum[i*LANE_W +: LANE_W],
                                                    bias_word[i*LANE_W +: LANE_W],
                                                    bias_on, relu_on);
    end
  end

  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      wb_tag <= '0;
    end else begin
      wb_tag <= tag;
    end
  end

  always_ff @(posedge kernel_rst) begin
    wb_word <= res_word;
  end

  ////////////////////
  // write-back routing
  ////////////////////
  // output bank is the one not used as input
  always_comb begin
    wr_a.valid = wb_tag.valid && cfg.in_is_b;
    wr_a.addr  = wb_tag.out_addr;
    wr_a.data  = wb_word;
    wr_b.valid = wb_tag.valid && !cfg.in_is_b;
    wr_b.addr  = wb_tag.out_addr;
    wr_b.data  = wb_word;
  end

  assign wb_finish = wb_tag.valid && wb_tag.finish;

endmodule

// File: logic/agg_top.sv
/*
  aggregation kernel top: controller, fetch, multiply-accumulate and
  bias/ReLU write-back stages
*/
`timescale 1ns/1ps

module agg_top
  import agg_pkg::*;
(
  input  logic       kernel_rst,
  input  logic       kernel_clk,
  input  logic       start,
  input  agg_instr_t instr,
  output logic       done,
  input  logic       edge_valid,
  input  edge_beat_t edge_data,
  output logic       edge_ready,
  output rd_req_t    rd_a,
  output rd_req_t    rd_b,
  input  feat_word_t rd_a_data,
  input  feat_word_t rd_b_data,
  output logic       bias_rd_valid,
  output bias_addr_t bias_rd_addr,
  input  feat_word_t bias_data,
  output wr_req_t    wr_a,
  output wr_req_t    wr_b
);

  agg_instr_t cfg;
  stage_tag_t issue;
  buf_addr_t  in_addr;
  bias_addr_t bias_addr;
  stage_tag_t fetch_tag;
  feat_word_t fetch_in_word;
  feat_word_t fetch_out_word;
  feat_word_t fetch_bias;
  stage_tag_t add_tag;
  feat_word_t sum;
  feat_word_t add_bias;
  logic       wb_finish;

  agg_ctrl u_ctrl (
    .kernel_rst (kernel_rst),
    .kernel_clk (kernel_clk),
    .start      (start),
    .instr      (instr),
    .done       (done),
    .edge_valid (edge_valid),
    .edge_data  (edge_data),
    .edge_ready (edge_ready),
    .cfg        (cfg),
    .issue      (issue),
    .in_addr    (in_addr),
    .bias_addr  (bias_addr),
    .wb_finish  (wb_finish)
  );

  agg_fetch u_fetch (
    .kernel_rst    (kernel_rst),
    .kernel_clk    (kernel_clk),
    .cfg           (cfg),
    .issue         (issue),
    .in_addr       (in_addr),
    .bias_addr     (bias_addr),
    .rd_a          (rd_a),
    .rd_b          (rd_b),
    .rd_a_data     (rd_a_data),
    .rd_b_data     (rd_b_data),
    .bias_rd_valid (bias_rd_valid),
    .bias_rd_addr  (bias_rd_addr),
    .bias_data     (bias_data),
    .tag           (fetch_tag),
    .in_word       (fetch_in_word),
    .out_word      (fetch_out_word),
    .bias_word     (fetch_bias)
  );

  // weight rides in the tag
  agg_mac u_mac (
    .kernel_rst (kernel_rst),
    .kernel_clk (kernel_clk),
    .tag        (fetch_tag),
    .in_word    (fetch_in_word),
    .out_word   (fetch_out_word),
    .bias_word  (fetch_bias),
    .weight     (fetch_tag.weight),
    .add_tag    (add_tag),
    .sum        (sum),
    .add_bias   (add_bias)
  );

  agg_bias_relu u_bias_relu (
    .kernel_rst (kernel_rst),
    .kernel_clk (kernel_clk),
    .cfg        (cfg),
    .tag        (add_tag),
    .sum        (sum),
    .bias_word  (add_bias),
    .wr_a       (wr_a),
    .wr_b       (wr_b),
    .wb_finish  (wb_finish)
  );

endmodule

// File: test/agg_chk.sv
/*
  aggregation kernel protocol assertions, bound to the top level
*/
`timescale 1ns/1ps

module agg_chk
  import agg_pkg::*;
(
  input logic    kernel_rst,
  input logic    kernel_clk,
  input logic    edge_valid,
  input logic    edge_ready,
  input logic    done,
  input wr_req_t wr_a,
  input wr_req_t wr_b
);

  // count of failed assertions
  int assert_fails = 0;

  // ready drops once a beat is taken
  assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    (edge_valid && edge_ready) |=> !edge_ready)
    else begin
      assert_fails++;
      $error("edge_ready stayed high after an accepted beat");
    end

  // only the output bank is written
  assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    !(wr_a.valid && wr_b.valid))
    else begin
      assert_fails++;
      $error("both bank writes valid in one cycle");
    end

  assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    done |=> !done)
    else begin
      assert_fails++;
      $error("done held longer than one cycle");
    end

endmodule

bind agg_top agg_chk chk0 (
  .kernel_rst (kernel_rst),
  .kernel_clk (kernel_clk),
  .edge_valid (edge_valid),
  .edge_ready (edge_ready),
  .done       (done),
  .wr_a       (wr_a),
  .wr_b       (wr_b)
);

// File: test/agg_tb.sv
/*
  aggregation kernel testbench: bank and bias buffer models, golden model,
  table of instructions and edge lists, checks and watchdog
*/
`timescale 1ns/1ps

module agg_tb
  import agg_pkg::*;
();

  typedef struct {
    int first_edge;
    int n_edges;
    int in_start;
    int out_start;
    int apf;
    int bias_start;
    bit bias_en;
    bit relu_en;
    bit in_is_b;
    int stall_pct;
    // reuse the banks left by the previous row
    bit keep_mem;
  } test_row_t;

  logic       kernel_rst;
  logic       kernel_clk;
  logic       start;
  agg_instr_t instr;
  logic       done;
  logic       edge_valid;
  edge_beat_t edge_data;
  logic       edge_ready;
  rd_req_t    rd_a;
  rd_req_t    rd_b;
  feat_word_t rd_a_data;
  feat_word_t rd_b_data;
  logic       bias_rd_valid;
  bias_addr_t bias_rd_addr;
  feat_word_t bias_data;
  wr_req_t    wr_a;
  wr_req_t    wr_b;

  feat_word_t bank_a [2**BUF_AW];
  feat_word_t bank_b [2**BUF_AW];
  feat_word_t bias_mem [2**BIAS_AW];
  feat_word_t gold_a [2**BUF_AW];
  feat_word_t gold_b [2**BUF_AW];
  feat_word_t a_pipe [BUF_RD_LAT];
  feat_word_t b_pipe [BUF_RD_LAT];
  feat_word_t c_pipe [BUF_RD_LAT];

  test_row_t rows [6];
  edge_t     edge_q [$];
  int        err_cnt;
  int        pass_cnt;
  int        fail_cnt;
  longint    limit_ns;

  agg_top dut0 (.*);

  // kernel_rst is the clock port
  initial begin
    kernel_rst = 1'b0;
    forever #5 kernel_rst = ~kernel_rst;
  end

  ////////////////////
  // buffer models
  ////////////////////
  always @(posedge kernel_rst) begin
    a_pipe[0] <= rd_a.valid ? bank_a[rd_a.addr] : '0;
    b_pipe[0] <= rd_b.valid ? bank_b[rd_b.addr] : '0;
    c_pipe[0] <= bias_rd_valid ? bias_mem[bias_rd_addr] : '0;
    for (int i = 1; i < BUF_RD_LAT; i++) begin
      a_pipe[i] <= a_pipe[i-1];
      b_pipe[i] <= b_pipe[i-1];
      c_pipe[i] <= c_pipe[i-1];
    end
    if (wr_a.valid) bank_a[wr_a.addr] <= wr_a.data;
    if (wr_b.valid) bank_b[wr_b.addr] <= wr_b.data;
  end

  assign rd_a_data = a_pipe[BUF_RD_LAT-1];
  assign rd_b_data = b_pipe[BUF_RD_LAT-1];
  assign bias_data = c_pipe[BUF_RD_LAT-1];

  ////////////////////
  // checks
  ////////////////////
  task automatic check_word(feat_word_t got, feat_word_t exp, string what, int addr);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s[%0d] got %h expected %h", $time, what, addr, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_done(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////
  // golden model
  ////////////////////
  function automatic feat_word_t expect_word(feat_word_t inw, feat_word_t acc, feat_word_t bias,
                                             lane_t w, bit add_b, bit clamp);
    feat_word_t r;
    lane_t      l;
    int         p;
    for (int i = 0; i < LANES; i++) begin
      p = int'($signed(inw[i*LANE_W +: LANE_W])) * int'(w);
      l = lane_t'(p) + lane_t'(acc[i*LANE_W +: LANE_W]);
      if (add_b) l = l + lane_t'(bias[i*LANE_W +: LANE_W]);
      if (clamp && l < 0) l = '0;
      r[i*LANE_W +: LANE_W] = l;
    end
    return r;
  endfunction

  task automatic run_golden(test_row_t row);
    edge_t      e;
    int         ia;
    int         oa;
    int         ba;
    feat_word_t inw;
    feat_word_t acc;
    feat_word_t res;
    for (int k = row.first_edge; k < row.first_edge + row.n_edges; k++) begin
      e = edge_q[k];
      for (int f = 0; f < row.apf; f++) begin
        ia  = (row.in_start + int'(e.src) * row.apf + f) % (2**BUF_AW);
        oa  = (row.out_start + int'(e.dst) * row.apf + f) % (2**BUF_AW);
        ba  = (row.bias_start + f) % (2**BIAS_AW);
        inw = row.in_is_b ? gold_b[ia] : gold_a[ia];
        acc = e.first ? '0 : (row.in_is_b ? gold_a[oa] : gold_b[oa]);
        res = expect_word(inw, acc, bias_mem[ba], lane_t'(e.weight[LANE_W-1:0]),
                          e.last && row.bias_en, e.last && row.relu_en);
        if (row.in_is_b) gold_a[oa] = res;
        else gold_b[oa] = res;
      end
    end
  endtask

  ////////////////////
  // stimulus table
  ////////////////////
  function automatic edge_t make_edge(bit first, int dst, bit last, int src, int w);
    edge_t e;
    e.first  = first;
    e.dst    = 15'(dst);
    e.last   = last;
    e.src    = 15'(src);
    e.weight = 32'(w);
    return e;
  endfunction

  task automatic build_table();
    // single edges, then one accumulated destination
    edge_q.push_back(make_edge(1, 0, 1, 4, 3));
    edge_q.push_back(make_edge(1, 1, 1, 5, -2));
    edge_q.push_back(make_edge(1, 2, 1, 6, 5));
    edge_q.push_back(make_edge(1, 3, 1, 7, 1));
    edge_q.push_back(make_edge(1, 1, 0, 0, 2));
    edge_q.push_back(make_edge(0, 1, 0, 1, -3));
    edge_q.push_back(make_edge(0, 1, 0, 2, 7));
    edge_q.push_back(make_edge(0, 1, 1, 3, 4));
    // bias and relu on two destinations
    edge_q.push_back(make_edge(1, 2, 0, 1, -5));
    edge_q.push_back(make_edge(0, 2, 1, 2, 9));
    edge_q.push_back(make_edge(1, 5, 0, 3, 6));
    edge_q.push_back(make_edge(0, 5, 1, 0, -1));
    // swapped banks
    edge_q.push_back(make_edge(1, 0, 1, 2, 11));
    edge_q.push_back(make_edge(1, 3, 0, 1, -4));
    edge_q.push_back(make_edge(0, 3, 1, 0, 3));
    edge_q.push_back(make_edge(1, 6, 1, 3, -7));
    // two beats under stalls
    edge_q.push_back(make_edge(1, 0, 0, 5, 2));
    edge_q.push_back(make_edge(0, 0, 0, 1, -6));
    edge_q.push_back(make_edge(0, 0, 1, 9, 3));
    edge_q.push_back(make_edge(1, 7, 1, 2, 13));
    edge_q.push_back(make_edge(1, 3, 0, 4, -2));
    edge_q.push_back(make_edge(0, 3, 1, 8, 5));
    edge_q.push_back(make_edge(1, 9, 0, 0, -9));
    edge_q.push_back(make_edge(0, 9, 1, 7, 4));
    // back to back with new fields
    edge_q.push_back(make_edge(1, 4, 0, 6, 8));
    edge_q.push_back(make_edge(0, 4, 1, 2, -3));
    edge_q.push_back(make_edge(1, 8, 1, 1, 5));
    edge_q.push_back(make_edge(1, 2, 1, 3, -12));
    rows[0] = '{0, 4, 0, 64, 2, 0, 0, 0, 0, 0, 0};
    rows[1] = '{4, 4, 16, 100, 3, 0, 0, 0, 0, 20, 0};
    rows[2] = '{8, 4, 8, 200, 2, 10, 1, 1, 0, 0, 0};
    rows[3] = '{12, 4, 40, 300, 4, 20, 1, 0, 1, 0, 0};
    rows[4] = '{16, 8, 0, 400, 2, 30, 0, 1, 0, 50, 0};
    rows[5] = '{24, 4, 500, 30, 1, 100, 1, 1, 1, 30, 1};
  endtask

  ////////////////////
  // drivers
  ////////////////////
  task automatic feed_beats(test_row_t row);
    int b;
    bit take;
    b    = 0;
    take = 1'b0;
    while (b < row.n_edges / EDGES_PER_BEAT) begin
      @(negedge kernel_rst);
      if (take) b++;
      take       = 1'b0;
      edge_valid = 1'b0;
      if (b < row.n_edges / EDGES_PER_BEAT) begin
        edge_valid = (int'($urandom_range(99)) >= row.stall_pct);
        for (int k = 0; k < EDGES_PER_BEAT; k++) begin
          edge_data[k*64 +: 64] = edge_q[row.first_edge + b*EDGES_PER_BEAT + k];
        end
        take = edge_valid && edge_ready;
      end
    end
  endtask

  task automatic wait_done();
    do @(negedge kernel_rst); while (done !== 1'b1);
    @(negedge kernel_rst);
    check_done(done, 1'b0, "done one cycle wide");
  endtask

  task automatic run_test(int r);
    test_row_t row;
    int        errs_before;
    row         = rows[r];
    errs_before = err_cnt;
    if (!row.keep_mem) begin
      for (int a = 0; a < 2**BUF_AW; a++) begin
        bank_a[a] = {$urandom, $urandom};
        bank_b[a] = {$urandom, $urandom};
      end
      for (int a = 0; a < 2**BIAS_AW; a++) bias_mem[a] = {$urandom, $urandom};
    end
    gold_a = bank_a;
    gold_b = bank_b;
    run_golden(row);
    instr                  = '0;
    instr.edge_count       = 16'(row.n_edges);
    instr.out_start        = 16'(row.out_start);
    instr.addr_per_feature = 8'(row.apf);
    instr.bias_start       = 8'(row.bias_start);
    instr.in_start         = 16'(row.in_start);
    instr.bias_en          = row.bias_en;
    instr.relu_en          = row.relu_en;
    instr.in_is_b          = row.in_is_b;
    start                  = 1'b1;
    @(negedge kernel_rst);
    start = 1'b0;
    fork
      feed_beats(row);
      wait_done();
    join
    for (int a = 0; a < 2**BUF_AW; a++) begin
      check_word(bank_a[a], gold_a[a], "bank a", a);
      check_word(bank_b[a], gold_b[a], "bank b", a);
    end
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %0d: %0d edges, %0d errors", r, row.n_edges, err_cnt - errs_before);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    void'($urandom(37));
    kernel_clk = 1'b1;
    start      = 1'b0;
    instr      = '0;
    edge_valid = 1'b0;
    edge_data  = '0;
    err_cnt    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    build_table();
    // edges times per-edge cycles, doubled, plus setup slack
    limit_ns = 1000;
    for (int r = 0; r < 6; r++) limit_ns += rows[r].n_edges * (rows[r].apf + 8) * 10 * 2;
    fork
      begin
        #(limit_ns);
        $display("watchdog expired after %0d ns without finishing", limit_ns);
        $display("FAIL: see errors above");
        $finish;
      end
    join_none
    repeat (3) @(negedge kernel_rst);
    kernel_clk = 1'b0;
    @(negedge kernel_rst);
    check_done(edge_ready, 1'b0, "edge_ready after reset");
    check_done(done, 1'b0, "done after reset");
    check_done(rd_a.valid || rd_b.valid || bias_rd_valid, 1'b0, "read valid after reset");
    check_done(wr_a.valid || wr_b.valid, 1'b0, "write valid after reset");
    @(negedge kernel_rst);
    for (int r = 0; r < 6; r++) run_test(r);
    // protocol assertion failures count as errors
    err_cnt += dut0.chk0.assert_fails;
    $display("%0d tests: %0d passed, %0d failed, %0d errors", 6, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: flist.f
logic/agg_pkg.sv
logic/agg_ctrl.sv
logic/agg_fetch.sv
logic/agg_mac.sv
logic/agg_bias_relu.sv
logic/agg_top.sv
test/agg_chk.sv
test/agg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the aggregation kernel testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module agg_tb -f flist.f -Mdir obj_dir -o agg_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/agg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
